//--- src/rsa_map_pkg.sv
package rsa_map_pkg;

  // Which operand bank a load writes.
  typedef enum logic {
    TGT_A = 1'b0,
    TGT_M = 1'b1
  } tgt_e;

  // How a buffer word is placed into the bank.
  typedef enum logic [1:0] {
    DIR_IDLE = 2'b00, // Clear the bank.
    DIR_POS  = 2'b01, // Straight copy.
    DIR_NEG  = 2'b10, // Lane-reversed.
    DIR_HALF = 2'b11  // One half into the low lanes.
  } dir_e;

endpackage

//--- src/rsa_cmd_pkg.sv
package rsa_cmd_pkg;

  localparam int CMD_W   = 16;
  localparam int ADDR_FW = 8;

  typedef enum logic {
    OP_LOAD = 1'b0,
    OP_MAC  = 1'b1
  } op_e;

  typedef struct packed {
    op_e                    op;
    rsa_map_pkg::tgt_e      tgt;
    rsa_map_pkg::dir_e      dir;
    logic                   half; // 1 picks the upper half.
    logic [CMD_W-ADDR_FW-6:0] pad;
    logic [ADDR_FW-1:0]     addr;
  } load_cmd_t;

  typedef struct packed {
    op_e              op;
    logic             clr; // Drop old accumulator value.
    logic [CMD_W-3:0] pad;
  } mac_cmd_t;

  // Op sits in the top bit of both views.
  typedef union packed {
    load_cmd_t ld;
    mac_cmd_t  mac;
  } rsa_cmd_u;

endpackage

//--- src/rsa_ctrl_if.sv
`timescale 1ns/1ps

interface rsa_ctrl_if #(
  parameter int DEPTH = 64
);

  logic                     rd_en;
  logic [$clog2(DEPTH)-1:0] rd_addr;

  logic                     map_vld;
  rsa_map_pkg::tgt_e        map_tgt;
  rsa_map_pkg::dir_e        map_dir;
  logic                     map_half;

  logic                     mac_en;
  logic                     mac_clr;

  modport ctrl (output rd_en, rd_addr, map_vld, map_tgt, map_dir, map_half, mac_en, mac_clr);
  modport bufp (input rd_en, rd_addr);
  modport dp   (input map_vld, map_tgt, map_dir, map_half, mac_en, mac_clr);

endinterface

//--- src/tb_buf.sv
`timescale 1ns/1ps

module tb_buf #(
  parameter int LANES = 4,
  parameter int DW    = 16,
  parameter int DEPTH = 64
) (
  input  logic                            clk,
  input  logic                            i_wr_en,
  input  logic [$clog2(DEPTH)-1:0]        i_wr_addr,
  input  logic signed [LANES*DW-1:0]      i_wr_data,
  rsa_ctrl_if.bufp                        rd,
  output logic signed [LANES*DW-1:0]      o_dout
);

  logic signed [LANES*DW-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Registered read, output held between reads.
  always_ff @(posedge clk) begin
    if (rd.rd_en) begin
      o_dout <= mem[rd.rd_addr];
    end
  end

endmodule

//--- src/tb_douta_map.sv
`timescale 1ns/1ps

module tb_douta_map #(
  parameter int LANES = 4,
  parameter int DW    = 16
) (
  input  logic                       clk,
  input  logic                       sys_rst,
  input  logic signed [LANES*DW-1:0] i_douta,
  rsa_ctrl_if.dp                     dp,
  output logic signed [LANES*DW-1:0] o_a_bank,
  output logic signed [LANES*DW-1:0] o_m_bank
);

  logic signed [LANES*DW-1:0] mapped;

  if (LANES % 2 != 0) begin : g_lanes_chk
    $error("tb_douta_map: LANES must be even, got %0d", LANES);
  end

  function automatic logic signed [LANES*DW-1:0] map_word(
    input rsa_map_pkg::dir_e          dir,
    input logic                       half,
    input logic signed [LANES*DW-1:0] din
  );
    logic signed [LANES*DW-1:0] r;
    int                         off;
    r   = '0;
    off = half ? LANES / 2 : 0;
    case (dir)
      rsa_map_pkg::DIR_IDLE: r = '0;
      rsa_map_pkg::DIR_POS:  r = din;
      rsa_map_pkg::DIR_NEG: begin
        for (int i = 0; i < LANES; i++) begin
          r[i*DW +: DW] = din[(LANES-1-i)*DW +: DW];
        end
      end
      default: begin
        // Chosen half lands in the low lanes, upper lanes stay zero.
        for (int i = 0; i < LANES / 2; i++) begin
          r[i*DW +: DW] = din[(i+off)*DW +: DW];
        end
      end
    endcase
    return r;
  endfunction

  assign mapped = map_word(dp.map_dir, dp.map_half, i_douta);

  // Only the targeted bank changes.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a_bank <= '0;
      o_m_bank <= '0;
    end else if (dp.map_vld) begin
      if (dp.map_tgt == rsa_map_pkg::TGT_A) begin
        o_a_bank <= mapped;
      end else begin
        o_m_bank <= mapped;
      end
    end
  end

endmodule

//--- src/rsa_ctrl.sv
`timescale 1ns/1ps

module rsa_ctrl #(
  parameter int DEPTH = 64
) (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  logic                  i_cmd_vld,
  input  rsa_cmd_pkg::rsa_cmd_u i_cmd,
  rsa_ctrl_if.ctrl              ctl
);

  localparam int AW = $clog2(DEPTH);

  logic                  s1_vld;
  rsa_cmd_pkg::rsa_cmd_u s1_cmd;
  logic                  s2_mac;
  logic                  s2_clr;

  // Stage 1: issue the buffer read and keep a copy of the command.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      ctl.rd_en <= 1'b0;
      s1_vld    <= 1'b0;
    end else begin
      ctl.rd_en <= i_cmd_vld && (i_cmd.ld.op == rsa_cmd_pkg::OP_LOAD);
      s1_vld    <= i_cmd_vld;
    end
  end

  always_ff @(posedge clk) begin
    s1_cmd <= i_cmd;
    if (i_cmd_vld && i_cmd.ld.op == rsa_cmd_pkg::OP_LOAD) begin
      ctl.rd_addr <= i_cmd.ld.addr[AW-1:0]; // Truncated to buffer range.
    end
  end

  // Stage 2: map fields line up with the buffer output.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      ctl.map_vld <= 1'b0;
      s2_mac      <= 1'b0;
    end else begin
      ctl.map_vld <= s1_vld && (s1_cmd.ld.op == rsa_cmd_pkg::OP_LOAD);
      s2_mac      <= s1_vld && (s1_cmd.mac.op == rsa_cmd_pkg::OP_MAC);
    end
  end

  always_ff @(posedge clk) begin
    ctl.map_tgt  <= s1_cmd.ld.tgt;
    ctl.map_dir  <= s1_cmd.ld.dir;
    ctl.map_half <= s1_cmd.ld.half;
    s2_clr       <= s1_cmd.mac.clr;
  end

  // Stage 3: MAC fires after every older load has hit its bank.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      ctl.mac_en <= 1'b0;
    end else begin
      ctl.mac_en <= s2_mac;
    end
  end

  always_ff @(posedge clk) begin
    ctl.mac_clr <= s2_clr;
  end

  a_addr_range: assert property (@(posedge clk) disable iff (sys_rst)
    (i_cmd_vld && i_cmd.ld.op == rsa_cmd_pkg::OP_LOAD) |-> (int'(i_cmd.ld.addr) < DEPTH))
    else $error("rsa_ctrl: load address %0d beyond DEPTH %0d", i_cmd.ld.addr, DEPTH);

  a_rd_after_rst: assert property (@(posedge clk) sys_rst |=> !ctl.rd_en)
    else $error("rsa_ctrl: rd_en high right after reset");

endmodule

//--- src/rsa_mac_array.sv
`timescale 1ns/1ps

module rsa_mac_array #(
  parameter int LANES = 4,
  parameter int DW    = 16,
  parameter int ACC_W = 36
) (
  input  logic                          clk,
  input  logic                          sys_rst,
  input  logic signed [LANES*DW-1:0]    i_a_bank,
  input  logic signed [LANES*DW-1:0]    i_m_bank,
  rsa_ctrl_if.dp                        dp,
  output logic signed [LANES*ACC_W-1:0] o_acc,
  output logic                          o_acc_vld
);

  logic signed [2*DW-1:0] prod [LANES];

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign prod[i] = $signed(i_a_bank[i*DW +: DW]) * $signed(i_m_bank[i*DW +: DW]);
  end

  // Wraps at ACC_W.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_acc <= '0;
    end else if (dp.mac_en) begin
      for (int i = 0; i < LANES; i++) begin
        o_acc[i*ACC_W +: ACC_W] <= (dp.mac_clr ? '0 : o_acc[i*ACC_W +: ACC_W])
                                   + ACC_W'(prod[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_acc_vld <= 1'b0;
    end else begin
      o_acc_vld <= dp.mac_en;
    end
  end

  a_vld_follow: assert property (@(posedge clk) disable iff (sys_rst)
    dp.mac_en |=> o_acc_vld)
    else $error("rsa_mac_array: o_acc_vld missing after mac_en");

  a_vld_cause: assert property (@(posedge clk) disable iff (sys_rst)
    o_acc_vld |-> $past(dp.mac_en))
    else $error("rsa_mac_array: o_acc_vld without mac_en");

endmodule

//--- src/rsa_top.sv
`timescale 1ns/1ps

module rsa_top #(
  parameter int LANES = 4,
  parameter int DW    = 16,
  parameter int ACC_W = 36,
  parameter int DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          sys_rst,
  input  logic                          i_wr_en,
  input  logic [$clog2(DEPTH)-1:0]      i_wr_addr,
  input  logic signed [LANES*DW-1:0]    i_wr_data,
  input  logic                          i_cmd_vld,
  input  logic [rsa_cmd_pkg::CMD_W-1:0] i_cmd,
  output logic signed [LANES*ACC_W-1:0] o_acc,
  output logic                          o_acc_vld
);

  logic signed [LANES*DW-1:0] buf_dout;
  logic signed [LANES*DW-1:0] a_bank;
  logic signed [LANES*DW-1:0] m_bank;

  rsa_ctrl_if #(.DEPTH(DEPTH)) ctrl_bus ();

  rsa_ctrl #(.DEPTH(DEPTH)) u_ctrl (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_cmd_vld (i_cmd_vld),
    .i_cmd     (i_cmd),
    .ctl       (ctrl_bus.ctrl)
  );

  tb_buf #(.LANES(LANES), .DW(DW), .DEPTH(DEPTH)) u_buf (
    .clk       (clk),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .rd        (ctrl_bus.bufp),
    .o_dout    (buf_dout)
  );

  tb_douta_map #(.LANES(LANES), .DW(DW)) u_map (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .i_douta  (buf_dout),
    .dp       (ctrl_bus.dp),
    .o_a_bank (a_bank),
    .o_m_bank (m_bank)
  );

  rsa_mac_array #(.LANES(LANES), .DW(DW), .ACC_W(ACC_W)) u_mac (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_a_bank  (a_bank),
    .i_m_bank  (m_bank),
    .dp        (ctrl_bus.dp),
    .o_acc     (o_acc),
    .o_acc_vld (o_acc_vld)
  );

endmodule

//--- verification/rsa_tb.sv
`timescale 1ns/1ps

module rsa_tb;

  localparam int LANES     = 4;
  localparam int DW        = 16;
  localparam int ACC_W     = 36;
  localparam int DEPTH     = 64;
  localparam int AW        = $clog2(DEPTH);
  localparam int WRAP_MACS = 40;
  localparam int BURST     = 60;
  localparam int TOTAL_CMDS = 11 + 8 + 8 + 7 + 4 + WRAP_MACS + BURST; // Per test, in order.

  logic                          clk;
  logic                          sys_rst;
  logic                          i_wr_en;
  logic [AW-1:0]                 i_wr_addr;
  logic signed [LANES*DW-1:0]    i_wr_data;
  logic                          i_cmd_vld;
  logic [rsa_cmd_pkg::CMD_W-1:0] i_cmd;
  logic signed [LANES*ACC_W-1:0] o_acc;
  logic                          o_acc_vld;

  // Reference model state.
  logic signed [DW-1:0]    buf_m [DEPTH][LANES];
  logic signed [DW-1:0]    bank_a [LANES];
  logic signed [DW-1:0]    bank_m [LANES];
  logic signed [ACC_W-1:0] acc_m [LANES];
  logic [LANES*ACC_W-1:0]  exp_mem [256]; // Expected results, oldest at rd_ptr.
  logic [LANES*ACC_W-1:0]  exp_head;
  logic [7:0]              wr_ptr;
  logic [7:0]              rd_ptr;
  int                      err_cnt = 0;
  int                      err_mark = 0;
  int                      test_cnt = 0;
  int                      test_bad = 0;

  rsa_top #(.LANES(LANES), .DW(DW), .ACC_W(ACC_W), .DEPTH(DEPTH)) DUT (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_cmd_vld (i_cmd_vld),
    .i_cmd     (i_cmd),
    .o_acc     (o_acc),
    .o_acc_vld (o_acc_vld)
  );

  always #2 clk = ~clk;

  assign exp_head = exp_mem[rd_ptr];

  always @(posedge clk) begin
    if (sys_rst) begin
      rd_ptr <= '0;
    end else if (o_acc_vld) begin
      rd_ptr <= rd_ptr + 8'd1;
    end
  end

  a_reset_state: assert property (@(posedge clk) $fell(sys_rst) |-> (o_acc == '0) && !o_acc_vld)
    else begin
      $display("CHECK FAILED o_acc/o_acc_vld after reset: got %h/%h", $sampled(o_acc),
               $sampled(o_acc_vld));
      err_cnt++;
    end

  a_acc_match: assert property (@(posedge clk) disable iff (sys_rst)
    o_acc_vld |-> (wr_ptr != rd_ptr) && (o_acc == exp_head))
    else begin
      $display("CHECK FAILED o_acc: expected %h got %h", $sampled(exp_head), $sampled(o_acc));
      err_cnt++;
    end

  a_mac_latency: assert property (@(posedge clk) disable iff (sys_rst)
    (i_cmd_vld && i_cmd[rsa_cmd_pkg::CMD_W-1]) |-> ##4 o_acc_vld)
    else begin
      $display("o_acc_vld did not arrive 4 cycles after a MAC command");
      err_cnt++;
    end

  function automatic logic signed [LANES*DW-1:0] rand_word();
    logic signed [LANES*DW-1:0] w;
    for (int i = 0; i < LANES; i++) begin
      w[i*DW +: DW] = DW'($urandom);
    end
    return w;
  endfunction

  task automatic idle();
    @(posedge clk);
    i_wr_en   <= 1'b0;
    i_cmd_vld <= 1'b0;
  endtask

  task automatic write_word(input logic [AW-1:0] addr, input logic signed [LANES*DW-1:0] data);
    for (int i = 0; i < LANES; i++) begin
      buf_m[addr][i] = data[i*DW +: DW];
    end
    @(posedge clk);
    i_wr_en   <= 1'b1;
    i_wr_addr <= addr;
    i_wr_data <= data;
    i_cmd_vld <= 1'b0;
  endtask

  task automatic issue_load(input rsa_map_pkg::tgt_e tgt, input rsa_map_pkg::dir_e dir,
                            input logic half, input logic [AW-1:0] addr);
    rsa_cmd_pkg::rsa_cmd_u c;
    logic signed [DW-1:0]  v;
    c         = '0;
    c.ld.op   = rsa_cmd_pkg::OP_LOAD;
    c.ld.tgt  = tgt;
    c.ld.dir  = dir;
    c.ld.half = half;
    c.ld.addr = rsa_cmd_pkg::ADDR_FW'(addr);
    for (int i = 0; i < LANES; i++) begin
      case (dir)
        rsa_map_pkg::DIR_IDLE: v = '0;
        rsa_map_pkg::DIR_POS:  v = buf_m[addr][i];
        rsa_map_pkg::DIR_NEG:  v = buf_m[addr][LANES-1-i];
        default: v = (i < LANES / 2) ? buf_m[addr][i + (half ? LANES / 2 : 0)] : '0;
      endcase
      if (tgt == rsa_map_pkg::TGT_A) bank_a[i] = v;
      else bank_m[i] = v;
    end
    @(posedge clk);
    i_cmd_vld <= 1'b1;
    i_cmd     <= c;
    i_wr_en   <= 1'b0;
  endtask

  task automatic issue_mac(input logic clr);
    rsa_cmd_pkg::rsa_cmd_u  c;
    logic signed [2*DW-1:0] p;
    c       = '0;
    c.mac.op  = rsa_cmd_pkg::OP_MAC;
    c.mac.clr = clr;
    for (int i = 0; i < LANES; i++) begin
      p = (2*DW)'(bank_a[i]) * (2*DW)'(bank_m[i]);
      if (clr) acc_m[i] = '0;
      acc_m[i] = acc_m[i] + ACC_W'(p); // Wraps at ACC_W.
      exp_mem[wr_ptr][i*ACC_W +: ACC_W] = acc_m[i];
    end
    wr_ptr = wr_ptr + 8'd1;
    @(posedge clk);
    i_cmd_vld <= 1'b1;
    i_cmd     <= c;
    i_wr_en   <= 1'b0;
  endtask

  task automatic end_test(input string name);
    idle();
    while (wr_ptr != rd_ptr) begin
      @(posedge clk);
    end
    @(posedge clk);
    test_cnt++;
    if (err_cnt != err_mark) test_bad++;
    $display("test %0d %-12s %s", test_cnt, name, (err_cnt == err_mark) ? "ok" : "errors");
    err_mark = err_cnt;
  endtask

  initial begin
    int pick;
    void'($urandom(32'hc76cc506));
    clk       = 1'b0;
    sys_rst   = 1'b1;
    i_wr_en   = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    i_cmd_vld = 1'b0;
    i_cmd     = '0;
    wr_ptr    = '0;
    for (int a = 0; a < DEPTH; a++) begin
      for (int i = 0; i < LANES; i++) buf_m[a][i] = '0;
    end
    for (int i = 0; i < LANES; i++) begin
      bank_a[i] = '0;
      bank_m[i] = '0;
      acc_m[i]  = '0;
    end
    repeat (2) @(posedge clk);
    sys_rst <= 1'b0;

    for (int a = 0; a < 8; a++) write_word(AW'(a), rand_word());
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_POS, 1'b0, AW'(0));
    issue_load(rsa_map_pkg::TGT_M, rsa_map_pkg::DIR_POS, 1'b0, AW'(1));
    issue_mac(1'b1);
    end_test("straight");

    write_word(AW'(2), rand_word());
    write_word(AW'(3), rand_word());
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_NEG, 1'b0, AW'(2));
    issue_load(rsa_map_pkg::TGT_M, rsa_map_pkg::DIR_POS, 1'b0, AW'(3));
    issue_mac(1'b1);
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_POS, 1'b0, AW'(2));
    issue_load(rsa_map_pkg::TGT_M, rsa_map_pkg::DIR_NEG, 1'b0, AW'(3));
    issue_mac(1'b1);
    end_test("reverse");

    issue_load(rsa_map_pkg::TGT_M, rsa_map_pkg::DIR_POS, 1'b0, AW'(1));
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_HALF, 1'b0, AW'(4));
    issue_mac(1'b1);
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_HALF, 1'b1, AW'(4));
    issue_mac(1'b1);
    issue_load(rsa_map_pkg::TGT_M, rsa_map_pkg::DIR_HALF, 1'b1, AW'(3));
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_POS, 1'b0, AW'(4));
    issue_mac(1'b1);
    end_test("half");

    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_POS, 1'b0, AW'(0));
    issue_load(rsa_map_pkg::TGT_M, rsa_map_pkg::DIR_POS, 1'b0, AW'(1));
    issue_mac(1'b1);
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_IDLE, 1'b0, AW'(0));
    issue_mac(1'b0);
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_POS, 1'b0, AW'(2)); // M still held.
    issue_mac(1'b0);
    end_test("clear_hold");

    // Most negative operands push the accumulators past ACC_W.
    write_word(AW'(8), {LANES{16'sh8000}});
    issue_load(rsa_map_pkg::TGT_A, rsa_map_pkg::DIR_POS, 1'b0, AW'(8));
    issue_load(rsa_map_pkg::TGT_M, rsa_map_pkg::DIR_POS, 1'b0, AW'(8));
    issue_mac(1'b1);
    repeat (WRAP_MACS) issue_mac(1'b0);
    for (int n = 0; n < BURST; n++) begin
      pick = int'($urandom_range(0, 5));
      if (pick == 0) begin
        write_word(AW'($urandom_range(0, 7)), rand_word());
      end else if (pick < 4) begin
        issue_load(rsa_map_pkg::tgt_e'(1'($urandom_range(0, 1))),
                   rsa_map_pkg::dir_e'(2'($urandom_range(0, 3))),
                   1'($urandom_range(0, 1)), AW'($urandom_range(0, 7)));
      end else begin
        issue_mac(1'($urandom_range(0, 1)));
      end
    end
    end_test("accumulate");

    $display("tests run %0d, tests with errors %0d, check failures %0d", test_cnt, test_bad,
             err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(TOTAL_CMDS * 4 * 2 + 300);
    $display("Timeout: the tests did not finish in the expected time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- sim.f
src/rsa_map_pkg.sv
src/rsa_cmd_pkg.sv
src/rsa_ctrl_if.sv
src/tb_buf.sv
src/tb_douta_map.sv
src/rsa_ctrl.sv
src/rsa_mac_array.sv
src/rsa_top.sv
verification/rsa_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module rsa_tb -f sim.f -o rsa_sim

./obj_dir/rsa_sim | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "Simulation passed."
  exit 0
fi
echo "Simulation failed, see sim.log."
exit 1
